/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_llc_cache
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -Wno-fatal -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "Done: no errors" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* build.f */
rtl/llc_pkg.sv
rtl/array.sv
rtl/data_array.sv
rtl/cache_datapath.sv
rtl/cache_control.sv
rtl/llc_cache.sv
tb/llc_cache_chk.sv
tb/tb_llc_cache.sv

/* rtl/array.sv */
module array #(
    parameter int s_index = 3,
    parameter int width   = 1
) (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               load_i,
    input  logic [s_index-1:0] index_i,
    input  logic [width-1:0]   data_i,
    output logic [width-1:0]   data_o
);

    localparam int num_sets = 2**s_index;

    logic [width-1:0] mem [num_sets];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < num_sets; i++) begin
                mem[i] <= '0;
            end
        end else if (load_i) begin
            mem[index_i] <= data_i;
        end
    end

    // combinational read
    assign data_o = mem[index_i];

endmodule : array

/* rtl/cache_control.sv */
module cache_control
    import llc_pkg::*;
(
    input  logic             clk,
    input  logic             arst_n_i,
    input  logic             cpu_req_valid_i,
    input  logic             cpu_we_i,
    input  logic             hit_i,
    input  logic [way_w-1:0] hit_way_i,
    input  logic [way_w-1:0] victim_way_i,
    input  logic             victim_dirty_i,
    input  logic             mem_credit_i,
    input  logic             mem_resp_valid_i,
    output logic             cpu_credit_o,
    output logic             cpu_resp_valid_o,
    output logic             mem_req_valid_o,
    output logic             mem_req_we_o,
    output logic             capture_o,
    output logic [way_w-1:0] way_sel_o,
    output dimux_sel_t       dimux_sel_o,
    output wemux_sel_t       wemux_sel_o,
    output addrmux_sel_t     addrmux_sel_o,
    output logic             tag_load_o,
    output logic             valid_load_o,
    output logic             dirty_load_o,
    output logic             lru_load_o,
    output logic             valid_in_o,
    output logic             dirty_in_o
);

    localparam logic [2:0] idle      = 3'd0;
    localparam logic [2:0] lookup    = 3'd1;
    localparam logic [2:0] wb_req    = 3'd2;
    localparam logic [2:0] wb_wait   = 3'd3;
    localparam logic [2:0] fill_req  = 3'd4;
    localparam logic [2:0] fill_wait = 3'd5;

    localparam int credit_w = 4;

    logic [2:0]          state_q;
    logic [2:0]          state_d;
    logic [credit_w-1:0] credit_q;
    logic [credit_w-1:0] credit_d;
    logic                init_q;
    logic                we_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q  <= idle;
            credit_q <= '0;
            init_q   <= 1'b1;
        end else begin
            state_q  <= state_d;
            credit_q <= credit_d;
            init_q   <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (capture_o) begin
            we_q <= cpu_we_i;
        end
    end

    // credit back once after reset, then with every response
    assign cpu_credit_o = init_q || cpu_resp_valid_o;

    always_comb begin
        state_d          = state_q;
        capture_o        = 1'b0;
        cpu_resp_valid_o = 1'b0;
        mem_req_valid_o  = 1'b0;
        mem_req_we_o     = 1'b0;
        way_sel_o        = hit_way_i;
        dimux_sel_o      = cpu_merge;
        wemux_sel_o      = zeros;
        addrmux_sel_o    = cpu_line;
        tag_load_o       = 1'b0;
        valid_load_o     = 1'b0;
        dirty_load_o     = 1'b0;
        lru_load_o       = 1'b0;
        valid_in_o       = 1'b0;
        dirty_in_o       = 1'b0;
        unique case (state_q)
            idle: begin
                if (cpu_req_valid_i) begin
                    capture_o = 1'b1;
                    state_d   = lookup;
                end
            end
            lookup: begin
                if (hit_i) begin
                    cpu_resp_valid_o = 1'b1;
                    lru_load_o       = 1'b1;
                    if (we_q) begin
                        wemux_sel_o  = byte_mask;
                        dirty_load_o = 1'b1;
                        dirty_in_o   = 1'b1;
                    end
                    state_d = idle;
                end else if (victim_dirty_i) begin
                    state_d = wb_req;
                end else begin
                    state_d = fill_req;
                end
            end
            wb_req: begin
                way_sel_o     = victim_way_i;
                addrmux_sel_o = victim_line;
                mem_req_we_o  = 1'b1;
                if (credit_q != '0) begin
                    mem_req_valid_o = 1'b1;
                    state_d         = wb_wait;
                end
            end
            wb_wait: begin
                way_sel_o = victim_way_i;
                if (mem_resp_valid_i) begin
                    state_d = fill_req;
                end
            end
            fill_req: begin
                if (credit_q != '0) begin
                    mem_req_valid_o = 1'b1;
                    state_d         = fill_wait;
                end
            end
            fill_wait: begin
                way_sel_o   = victim_way_i;
                dimux_sel_o = mem_fill;
                if (mem_resp_valid_i) begin
                    // install clean line, lookup then hits
                    wemux_sel_o  = ones;
                    tag_load_o   = 1'b1;
                    valid_load_o = 1'b1;
                    valid_in_o   = 1'b1;
                    dirty_load_o = 1'b1;
                    state_d      = lookup;
                end
            end
            default: state_d = idle;
        endcase
    end

    // saturates, a grant and a spend in one cycle cancel
    always_comb begin
        credit_d = credit_q;
        if (mem_credit_i && !mem_req_valid_o) begin
            if (credit_q != '1) begin
                credit_d = credit_q + 1'b1;
            end
        end else if (!mem_credit_i && mem_req_valid_o) begin
            credit_d = credit_q - 1'b1;
        end
    end

endmodule : cache_control

/* rtl/cache_datapath.sv */
module cache_datapath
    import llc_pkg::*;
#(
    parameter int s_index = 3
) (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                capture_i,
    input  logic [word_w-1:0]   cpu_addr_i,
    input  logic [word_w-1:0]   cpu_wdata_i,
    input  logic [word_w/8-1:0] cpu_be_i,
    input  logic [way_w-1:0]    way_sel_i,
    input  dimux_sel_t          dimux_sel_i,
    input  wemux_sel_t          wemux_sel_i,
    input  addrmux_sel_t        addrmux_sel_i,
    input  logic                tag_load_i,
    input  logic                valid_load_i,
    input  logic                dirty_load_i,
    input  logic                lru_load_i,
    input  logic                valid_in_i,
    input  logic                dirty_in_i,
    input  logic [line_w-1:0]   mem_rdata_i,
    output logic                hit_o,
    output logic [way_w-1:0]    hit_way_o,
    output logic [way_w-1:0]    victim_way_o,
    output logic                victim_dirty_o,
    output logic [word_w-1:0]   cpu_rdata_o,
    output logic [word_w-1:0]   mem_addr_o,
    output logic [line_w-1:0]   mem_wdata_o
);

    localparam int s_tag  = word_w - s_offset - s_index;
    localparam int s_word = s_offset - 2;

    logic [word_w-1:0]         req_addr_q;
    logic [word_w-1:0]         req_wdata_q;
    logic [word_w/8-1:0]       req_be_q;
    logic [s_index-1:0]        set;
    logic [s_tag-1:0]          tag;
    logic [s_word-1:0]         word_sel;
    logic [num_ways-1:0]       valid_out;
    logic [num_ways-1:0]       dirty_out;
    logic [num_ways-1:0]       hit_vec;
    logic [s_tag-1:0]          tag_out [num_ways];
    llc_line_u                 line_out [num_ways];
    logic [2:0]                lru_out;
    logic [2:0]                lru_next;
    logic [way_w-1:0]          plru_way;
    llc_line_u                 way_line;
    llc_line_u                 merge_line;
    llc_line_u                 din;
    logic [bytes_per_line-1:0] be_mask;
    logic [bytes_per_line-1:0] we_line;

    always_ff @(posedge clk) begin
        if (capture_i) begin
            req_addr_q  <= cpu_addr_i;
            req_wdata_q <= cpu_wdata_i;
            req_be_q    <= cpu_be_i;
        end
    end

    assign set      = req_addr_q[s_offset +: s_index];
    assign tag      = req_addr_q[word_w-1 -: s_tag];
    assign word_sel = req_addr_q[2 +: s_word];

    array #(.s_index(s_index), .width(3)) u_lru (
        .clk, .arst_n_i, .load_i(lru_load_i), .index_i(set),
        .data_i(lru_next), .data_o(lru_out)
    );

    for (genvar w = 0; w < num_ways; w++) begin : g_way
        logic sel;
        assign sel = (way_sel_i == way_w'(w));

        array #(.s_index(s_index), .width(1)) u_valid (
            .clk, .arst_n_i, .load_i(valid_load_i && sel), .index_i(set),
            .data_i(valid_in_i), .data_o(valid_out[w])
        );
        array #(.s_index(s_index), .width(1)) u_dirty (
            .clk, .arst_n_i, .load_i(dirty_load_i && sel), .index_i(set),
            .data_i(dirty_in_i), .data_o(dirty_out[w])
        );
        array #(.s_index(s_index), .width(s_tag)) u_tag (
            .clk, .arst_n_i, .load_i(tag_load_i && sel), .index_i(set),
            .data_i(tag), .data_o(tag_out[w])
        );
        data_array #(.s_index(s_index)) u_data (
            .clk, .byte_we_i(sel ? we_line : '0), .index_i(set),
            .data_i(din), .data_o(line_out[w])
        );

        assign hit_vec[w] = valid_out[w] && (tag_out[w] == tag);
    end

    assign hit_o = |hit_vec;

    always_comb begin
        hit_way_o = '0;
        for (int i = 0; i < num_ways; i++) begin
            if (hit_vec[i]) begin
                hit_way_o = way_w'(i);
            end
        end
    end

    // tree bits point away from the touched way
    always_comb begin
        lru_next    = lru_out;
        lru_next[0] = ~way_sel_i[1];
        if (way_sel_i[1]) begin
            lru_next[2] = ~way_sel_i[0];
        end else begin
            lru_next[1] = ~way_sel_i[0];
        end
    end

    assign plru_way = lru_out[0] ? {1'b1, lru_out[2]} : {1'b0, lru_out[1]};

    // lowest invalid way wins over the tree
    always_comb begin
        victim_way_o = plru_way;
        for (int i = num_ways - 1; i >= 0; i--) begin
            if (!valid_out[i]) begin
                victim_way_o = way_w'(i);
            end
        end
    end

    assign victim_dirty_o = valid_out[victim_way_o] && dirty_out[victim_way_o];

    assign way_line    = line_out[way_sel_i];
    assign cpu_rdata_o = way_line.words[word_sel];
    assign mem_wdata_o = way_line.bits;

    always_comb begin
        merge_line                 = way_line;
        merge_line.words[word_sel] = req_wdata_q;
        be_mask                    = '0;
        be_mask[word_sel*4 +: 4]   = req_be_q;
    end

    always_comb begin
        unique case (wemux_sel_i)
            zeros:     we_line = '0;
            ones:      we_line = '1;
            byte_mask: we_line = be_mask;
            default:   we_line = '0;
        endcase
        unique case (dimux_sel_i)
            cpu_merge: din = merge_line;
            mem_fill:  din.bits = mem_rdata_i;
            default:   din = merge_line;
        endcase
        unique case (addrmux_sel_i)
            cpu_line:    mem_addr_o = {tag, set, {s_offset{1'b0}}};
            victim_line: mem_addr_o = {tag_out[way_sel_i], set, {s_offset{1'b0}}};
            default:     mem_addr_o = {tag, set, {s_offset{1'b0}}};
        endcase
    end

endmodule : cache_datapath

/* rtl/data_array.sv */
module data_array
    import llc_pkg::*;
#(
    parameter int s_index = 3
) (
    input  logic                      clk,
    input  logic [bytes_per_line-1:0] byte_we_i,
    input  logic [s_index-1:0]        index_i,
    input  llc_line_u                 data_i,
    output llc_line_u                 data_o
);

    localparam int num_sets = 2**s_index;

    logic [line_w-1:0] mem [num_sets];

    // each byte lane written only where enabled
    always_ff @(posedge clk) begin
        for (int b = 0; b < bytes_per_line; b++) begin
            if (byte_we_i[b]) begin
                mem[index_i][8*b +: 8] <= data_i.bits[8*b +: 8];
            end
        end
    end

    assign data_o.bits = mem[index_i];

endmodule : data_array

/* rtl/llc_cache.sv */
module llc_cache
    import llc_pkg::*;
#(
    parameter int s_index = 3
) (
    input  logic                clk,
    input  logic                arst_n_i,
    output logic                cpu_credit_o,
    input  logic                cpu_req_valid_i,
    input  logic [word_w-1:0]   cpu_addr_i,
    input  logic                cpu_we_i,
    input  logic [word_w-1:0]   cpu_wdata_i,
    input  logic [word_w/8-1:0] cpu_be_i,
    output logic                cpu_resp_valid_o,
    output logic [word_w-1:0]   cpu_rdata_o,
    input  logic                mem_credit_i,
    output logic                mem_req_valid_o,
    output logic                mem_req_we_o,
    output logic [word_w-1:0]   mem_addr_o,
    output logic [line_w-1:0]   mem_wdata_o,
    input  logic                mem_resp_valid_i,
    input  logic [line_w-1:0]   mem_rdata_i
);

    logic             hit;
    logic [way_w-1:0] hit_way;
    logic [way_w-1:0] victim_way;
    logic             victim_dirty;
    logic             capture;
    logic [way_w-1:0] way_sel;
    dimux_sel_t       dimux_sel;
    wemux_sel_t       wemux_sel;
    addrmux_sel_t     addrmux_sel;
    logic             tag_load;
    logic             valid_load;
    logic             dirty_load;
    logic             lru_load;
    logic             valid_in;
    logic             dirty_in;

    cache_control u_control (
        .clk, .arst_n_i, .cpu_req_valid_i, .cpu_we_i,
        .hit_i(hit), .hit_way_i(hit_way), .victim_way_i(victim_way),
        .victim_dirty_i(victim_dirty), .mem_credit_i, .mem_resp_valid_i,
        .cpu_credit_o, .cpu_resp_valid_o, .mem_req_valid_o, .mem_req_we_o,
        .capture_o(capture), .way_sel_o(way_sel), .dimux_sel_o(dimux_sel),
        .wemux_sel_o(wemux_sel), .addrmux_sel_o(addrmux_sel),
        .tag_load_o(tag_load), .valid_load_o(valid_load), .dirty_load_o(dirty_load),
        .lru_load_o(lru_load), .valid_in_o(valid_in), .dirty_in_o(dirty_in)
    );

    cache_datapath #(.s_index(s_index)) u_datapath (
        .clk, .arst_n_i, .capture_i(capture), .cpu_addr_i, .cpu_wdata_i, .cpu_be_i,
        .way_sel_i(way_sel), .dimux_sel_i(dimux_sel), .wemux_sel_i(wemux_sel),
        .addrmux_sel_i(addrmux_sel), .tag_load_i(tag_load), .valid_load_i(valid_load),
        .dirty_load_i(dirty_load), .lru_load_i(lru_load), .valid_in_i(valid_in),
        .dirty_in_i(dirty_in), .mem_rdata_i,
        .hit_o(hit), .hit_way_o(hit_way), .victim_way_o(victim_way),
        .victim_dirty_o(victim_dirty), .cpu_rdata_o, .mem_addr_o, .mem_wdata_o
    );

endmodule : llc_cache

/* rtl/llc_pkg.sv */
package llc_pkg;

    localparam int word_w   = 32;
    localparam int line_w   = 256;
    localparam int s_offset = 5;
    localparam int num_ways = 4;

    localparam int way_w          = $clog2(num_ways);
    localparam int words_per_line = line_w / word_w;
    localparam int bytes_per_line = line_w / 8;

    // one cache line, raw or as words (word 0 in the low bits)
    typedef union packed {
        logic [line_w-1:0]                     bits;
        logic [words_per_line-1:0][word_w-1:0] words;
    } llc_line_u;

    // data written into the selected way
    typedef enum logic {
        cpu_merge,
        mem_fill
    } dimux_sel_t;

    // memory request address
    typedef enum logic {
        cpu_line,
        victim_line
    } addrmux_sel_t;

    // byte enables of the selected way
    typedef enum logic [1:0] {
        zeros,
        ones,
        byte_mask
    } wemux_sel_t;

endpackage : llc_pkg

/* tb/llc_cache_chk.sv */
module llc_cache_chk (
    input logic clk,
    input logic arst_n_i,
    input logic mem_credit_i,
    input logic mem_req_valid_i,
    input logic cpu_resp_valid_i,
    input logic cpu_credit_i
);

    timeunit 1ns;
    timeprecision 100ps;

    logic        first_credit_q;
    logic [15:0] granted_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            first_credit_q <= 1'b0;
        end else if (cpu_credit_i) begin
            first_credit_q <= 1'b1;
        end
    end

    // memory credits granted and not yet spent
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            granted_q <= '0;
        end else begin
            granted_q <= granted_q + 16'(mem_credit_i) - 16'(mem_req_valid_i);
        end
    end

    req_needs_credit: assert property (@(posedge clk) disable iff (!arst_n_i)
        mem_req_valid_i |-> granted_q != '0)
        else $error("memory request issued with an empty credit counter");

    resp_one_cycle: assert property (@(posedge clk) disable iff (!arst_n_i)
        cpu_resp_valid_i |=> !cpu_resp_valid_i)
        else $error("CPU response held longer than one cycle");

    // credits come back only with responses
    credit_with_resp: assert property (@(posedge clk) disable iff (!arst_n_i)
        first_credit_q |-> cpu_credit_i == cpu_resp_valid_i)
        else $error("CPU credit out of step with the response");

endmodule : llc_cache_chk

bind llc_cache llc_cache_chk u_chk (
    .clk,
    .arst_n_i,
    .mem_credit_i,
    .mem_req_valid_i(mem_req_valid_o),
    .cpu_resp_valid_i(cpu_resp_valid_o),
    .cpu_credit_i(cpu_credit_o)
);

/* tb/tb_llc_cache.sv */
module tb_llc_cache;

    timeunit 1ns;
    timeprecision 100ps;

    // about 70 accesses, a miss with write-back stays under 20 cycles
    localparam int max_cycles  = 4000;
    localparam int mem_latency = 3;

    logic         clk = 1'b0;
    logic         arst_n_i;
    logic         cpu_credit_o;
    logic         cpu_req_valid_i;
    logic [31:0]  cpu_addr_i;
    logic         cpu_we_i;
    logic [31:0]  cpu_wdata_i;
    logic [3:0]   cpu_be_i;
    logic         cpu_resp_valid_o;
    logic [31:0]  cpu_rdata_o;
    logic         mem_credit_i;
    logic         mem_req_valid_o;
    logic         mem_req_we_o;
    logic [31:0]  mem_addr_o;
    logic [255:0] mem_wdata_o;
    logic         mem_resp_valid_i;
    logic [255:0] mem_rdata_i;

    logic [255:0] mem_lines [64];
    logic [255:0] shadow [64];
    logic [31:0]  log_addr [$];
    logic         log_we [$];
    logic [255:0] log_data [$];
    logic [255:0] pend_rdata;
    logic         starve;
    logic [31:0]  last_rdata;
    int           resp_cnt;
    int           mem_seed = 96;
    int           mix_seed = 96;
    int           cycles;
    int           errors;
    int           test_base;
    int           credits;
    int           last_lat;

    always #2 clk = ~clk;

    llc_cache #(.s_index(3)) UUT (.*);

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("TIMEOUT: run stopped after %0d cycles", cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    // memory: line index is addr[10:5], one request in flight at most
    initial begin
        for (int i = 0; i < 64; i++) begin
            for (int w = 0; w < 8; w++) begin
                mem_lines[i][32*w +: 32] = $random(mem_seed);
            end
        end
        mem_credit_i     = 1'b0;
        mem_resp_valid_i = 1'b0;
        mem_rdata_i      = '0;
        resp_cnt         = 0;
        forever begin
            @(negedge clk);
            if (arst_n_i && mem_req_valid_o) begin
                log_addr.push_back(mem_addr_o);
                log_we.push_back(mem_req_we_o);
                log_data.push_back(mem_wdata_o);
                if (mem_req_we_o) begin
                    mem_lines[mem_addr_o[10:5]] = mem_wdata_o;
                end
                pend_rdata = mem_lines[mem_addr_o[10:5]];
                resp_cnt   = mem_latency;
            end
            @(posedge clk);
            #1;
            mem_credit_i     = !starve;
            mem_resp_valid_i = 1'b0;
            if (resp_cnt > 0) begin
                resp_cnt--;
                if (resp_cnt == 0) begin
                    mem_resp_valid_i = 1'b1;
                    mem_rdata_i      = pend_rdata;
                end
            end
        end
    end

    task automatic report_mismatch(input string sig, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("MISMATCH %s: expected %h, got %h", sig, expected, actual);
        errors++;
    endtask

    task automatic finish_test(input string name);
        $display("test %s: %0d errors", name, errors - test_base);
        test_base = errors;
    endtask

    task automatic apply_reset();
        arst_n_i = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        arst_n_i = 1'b1;
        @(negedge clk);
        if (cpu_resp_valid_o || mem_req_valid_o) begin
            $display("response or memory request active right after reset");
            errors++;
        end
        if (!cpu_credit_o) begin
            $display("no CPU credit in the first cycle after reset");
            errors++;
        end
        credits = cpu_credit_o ? 1 : 0;
    endtask

    task automatic send_request(input logic we, input logic [31:0] addr,
                                input logic [31:0] wdata, input logic [3:0] be);
        logic [5:0] idx;
        idx = addr[10:5];
        @(posedge clk);
        #1;
        if (credits == 0) begin
            $display("request to %h issued while holding no CPU credit", addr);
            errors++;
        end
        credits--;
        cpu_req_valid_i = 1'b1;
        cpu_we_i        = we;
        cpu_addr_i      = addr;
        cpu_wdata_i     = wdata;
        cpu_be_i        = be;
        @(posedge clk);
        #1;
        cpu_req_valid_i = 1'b0;
        if (we) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    shadow[idx][32*addr[4:2] + 8*b +: 8] = wdata[8*b +: 8];
                end
            end
        end
    endtask

    // counts cycles after the accept cycle
    task automatic wait_response();
        last_lat = 0;
        do begin
            @(negedge clk);
            last_lat++;
        end while (!cpu_resp_valid_o);
        last_rdata = cpu_rdata_o;
        if (cpu_credit_o) begin
            credits++;
        end
    endtask

    task automatic access(input logic we, input logic [31:0] addr,
                          input logic [31:0] wdata, input logic [3:0] be);
        logic [31:0] expected;
        send_request(we, addr, wdata, be);
        expected = shadow[addr[10:5]][32*addr[4:2] +: 32];
        wait_response();
        if (!we && last_rdata !== expected) begin
            report_mismatch("cpu_rdata_o", expected, last_rdata);
        end
    endtask

    task automatic check_write_back(input int base, input logic [31:0] addr);
        if (log_addr.size() < base + 2 || !log_we[base]) begin
            $display("no write-back ahead of the fill that replaced line %h", addr);
            errors++;
        end else begin
            if (log_addr[base] !== addr) begin
                report_mismatch("mem_addr_o", addr, log_addr[base]);
            end
            if (log_data[base] !== shadow[addr[10:5]]) begin
                $display("MISMATCH mem_wdata_o: expected %h, got %h",
                         shadow[addr[10:5]], log_data[base]);
                errors++;
            end
        end
    endtask

    task automatic read_miss_then_hit();
        int base;
        base = log_addr.size();
        access(1'b0, 32'h0000_0024, '0, '0);
        if (log_addr.size() != base + 1) begin
            $display("read miss made %0d memory requests, not one", log_addr.size() - base);
            errors++;
        end else begin
            if (log_we[base]) begin
                $display("read miss made a memory write instead of a read");
                errors++;
            end
            if (log_addr[base] !== 32'h0000_0020) begin
                report_mismatch("mem_addr_o", 32'h0000_0020, log_addr[base]);
            end
        end
        base = log_addr.size();
        access(1'b0, 32'h0000_002C, '0, '0);
        if (log_addr.size() != base) begin
            $display("read hit made a memory request");
            errors++;
        end
        if (last_lat != 1) begin
            $display("read hit answered %0d cycles after accept, not 1", last_lat);
            errors++;
        end
    endtask

    task automatic partial_write_merge();
        int          base;
        logic [31:0] old;
        logic [31:0] merged;
        base   = log_addr.size();
        old    = shadow[6'd1][64 +: 32];
        merged = {old[31:24], 8'hB2, old[15:8], 8'hD4};
        access(1'b1, 32'h0000_0028, 32'hA1B2_C3D4, 4'b0101);
        access(1'b0, 32'h0000_0028, '0, '0);
        if (last_rdata !== merged) begin
            report_mismatch("cpu_rdata_o", merged, last_rdata);
        end
        if (log_addr.size() != base) begin
            $display("partial write to a cached line reached memory");
            errors++;
        end
    endtask

    // set 0, lines A to F are tags 0 to 5
    task automatic plru_eviction();
        int base;
        for (int i = 0; i < 4; i++) begin
            access(1'b1, 32'h100 * i, 32'hD000_0000 + i, 4'hF);
        end
        // after D the tree points at way 0, which holds A
        base = log_addr.size();
        access(1'b0, 32'h0000_0400, '0, '0);
        check_write_back(base, 32'h0000_0000);
        // E in way 0, then A back into way 2, leaves the tree on way 1 (B)
        access(1'b0, 32'h0000_0000, '0, '0);
        base = log_addr.size();
        access(1'b0, 32'h0000_0500, '0, '0);
        check_write_back(base, 32'h0000_0100);
    endtask

    task automatic credit_starvation();
        logic [5:0]  k;
        logic [31:0] expected;
        starve = 1'b1;
        repeat (2) @(negedge clk);
        // spend the credits the cache already holds, one fill each in clean sets 2 to 7
        k = 6'd34;
        while (UUT.u_control.credit_q != 0) begin
            access(1'b0, {21'd0, k, 5'd0}, '0, '0);
            k = (k[2:0] == 3'd7) ? k + 6'd3 : k + 6'd1;
        end
        expected = shadow[6'd62][32 +: 32];
        send_request(1'b0, 32'h0000_07C4, '0, '0);
        repeat (20) begin
            @(negedge clk);
            if (mem_req_valid_o || cpu_resp_valid_o) begin
                $display("memory request or CPU response while memory credits withheld");
                errors++;
            end
        end
        starve = 1'b0;
        wait_response();
        if (last_rdata !== expected) begin
            report_mismatch("cpu_rdata_o", expected, last_rdata);
        end
    endtask

    // sets 1 and 2, six tags each
    task automatic random_mix();
        logic [31:0] r;
        logic [31:0] wdata;
        logic [2:0]  tag;
        logic [2:0]  set_sel;
        for (int n = 0; n < 40; n++) begin
            r       = $random(mix_seed);
            wdata   = $random(mix_seed);
            tag     = r[10:8] % 3'd6;
            set_sel = r[1] ? 3'd2 : 3'd1;
            access(r[0], {21'd0, tag, set_sel, r[4:2], 2'b00}, wdata, r[15:12]);
        end
    endtask

    initial begin
        cpu_req_valid_i = 1'b0;
        cpu_we_i        = 1'b0;
        cpu_addr_i      = '0;
        cpu_wdata_i     = '0;
        cpu_be_i        = '0;
        starve          = 1'b0;
        apply_reset();
        shadow = mem_lines;
        read_miss_then_hit();
        finish_test("read_miss_then_hit");
        partial_write_merge();
        finish_test("partial_write_merge");
        plru_eviction();
        finish_test("plru_eviction");
        credit_starvation();
        finish_test("credit_starvation");
        random_mix();
        finish_test("random_mix");
        $display("5 tests run, %0d errors", errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule : tb_llc_cache
